//--- src/ledkey_pkg.sv
package ledkey_pkg;

	localparam int HALF_BIT   = 2;   // cycles per serial clock phase
	localparam int WAIT_UNIT  = 40;  // cycles per script wait unit
	localparam int FIFO_DEPTH = 8;
	localparam int PTR_W      = $clog2(FIFO_DEPTH);

	localparam logic [7:0] ADDR_BASE  = 8'hC0;  // display address 0
	localparam logic [7:0] MODE_AUTO  = 8'h40;  // write, auto increment
	localparam logic [7:0] MODE_FIXED = 8'h44;  // write, fixed address
	localparam logic [7:0] MODE_READ  = 8'h42;  // key scan read

	// start-up script content
	localparam logic [7:0]  DISPLAY_ON    = 8'h88;
	localparam logic [63:0] INIT_TEXT     = "kill bit";
	localparam logic [3:0]  INIT_LED_IDX  = 4'd7;
	localparam logic [7:0]  INIT_LED_MASK = 8'b1100_1111;

	// the last two sequencer steps form the idle loop
	localparam logic [2:0] STEP_MODE  = 3'd0;
	localparam logic [2:0] STEP_CLEAR = 3'd1;
	localparam logic [2:0] STEP_ON    = 3'd2;
	localparam logic [2:0] STEP_TEXT  = 3'd3;
	localparam logic [2:0] STEP_LED   = 3'd4;
	localparam logic [2:0] STEP_MASK  = 3'd5;
	localparam logic [2:0] STEP_LOOP  = 3'd6;
	localparam logic [2:0] STEP_READ  = 3'd7;

	localparam logic [1:0] SEQ_SEND = 2'd0;  // handshake words out
	localparam logic [1:0] SEQ_WAIT = 2'd1;  // count idle cycles
	localparam logic [1:0] SEQ_READ = 2'd2;  // wait for key result

	localparam logic [2:0] SER_IDLE  = 3'd0;
	localparam logic [2:0] SER_LOAD  = 3'd1;
	localparam logic [2:0] SER_START = 3'd2;  // strobe low, clock still high
	localparam logic [2:0] SER_LOW   = 3'd3;
	localparam logic [2:0] SER_HIGH  = 3'd4;
	localparam logic [2:0] SER_GAP   = 3'd5;  // strobe high between frames

	typedef enum logic [2:0] {
		OP_CMD,    // single byte frame
		OP_OPEN,   // first byte, frame stays open
		OP_MORE,
		OP_CLOSE,  // last byte, frame ends
		OP_SEG,
		OP_LED,
		OP_READ
	} op_e;

	typedef union packed {
		struct packed {
			logic [3:0] pad;
			logic [7:0] data;
		} raw;
		struct packed {
			logic [3:0] idx;    // digit or LED number
			logic [7:0] value;
		} indexed;
	} payload_u;

	typedef struct packed {
		op_e      op;
		payload_u payload;
	} cmd_word_t;

	function automatic logic [7:0] glyph(input logic [7:0] c);
		case (c)
			"0": glyph = 8'h3F;
			"1": glyph = 8'h06;
			"2": glyph = 8'h5B;
			"3": glyph = 8'h4F;
			"4": glyph = 8'h66;
			"5": glyph = 8'h6D;
			"6": glyph = 8'h7D;
			"7": glyph = 8'h07;
			"8": glyph = 8'h7F;
			"9": glyph = 8'h6F;
			"a": glyph = 8'h5F;
			"b": glyph = 8'h7C;
			"c": glyph = 8'h58;
			"d": glyph = 8'h5E;
			"e": glyph = 8'h79;
			"f": glyph = 8'h71;
			"g": glyph = 8'h3D;
			"h": glyph = 8'h74;
			"i": glyph = 8'h11;
			"j": glyph = 8'h0D;
			"k": glyph = 8'h75;
			"l": glyph = 8'h38;
			"n": glyph = 8'h54;
			"o": glyph = 8'h5C;
			"p": glyph = 8'h73;
			"r": glyph = 8'h50;
			"s": glyph = 8'h2D;
			"t": glyph = 8'h78;
			"u": glyph = 8'h1C;
			"y": glyph = 8'h6E;
			" ": glyph = 8'h00;
			"-": glyph = 8'h40;
			"_": glyph = 8'h08;
			default: glyph = 8'h80;  // decimal point marks unknown
		endcase
	endfunction

endpackage

//--- src/ledkey_sequencer.sv
`timescale 1ns/10ps

module ledkey_sequencer import ledkey_pkg::*; (
	input  logic       i_clk,
	input  logic       rst_n,
	output logic       o_req,
	input  logic       i_ack,
	output cmd_word_t  o_word,
	input  logic       i_eng_idle,
	input  logic       i_btn_valid,
	input  logic [7:0] i_btn_state
);

	logic [1:0] state;
	logic [2:0] step;
	logic [4:0] sub;          // word number inside the step
	logic [2:0] led_pos;      // lit LED of the idle loop
	logic       btn_any;      // some key held at the last read
	logic [7:0] wait_cnt;
	logic [4:0] last_sub;
	logic [1:0] wait_units;
	logic [7:0] wait_cycles;
	logic [7:0] burst_byte;
	logic       drained;

	// address first, then zeros or glyph/zero pairs
	always_comb begin
		if (sub == 5'd0)
			burst_byte = ADDR_BASE;
		else if (step == STEP_TEXT && sub[0])
			burst_byte = glyph(INIT_TEXT[{~sub[3:1], 3'b000} +: 8]);
		else
			burst_byte = 8'h00;
	end

	always_comb begin
		o_word = '0;
		last_sub = 5'd0;
		wait_units = 2'd0;
		case (step)
			STEP_MODE: begin
				o_word.op = OP_CMD;
				o_word.payload.raw.data = MODE_AUTO;
			end
			STEP_CLEAR, STEP_TEXT: begin
				o_word.op = (sub == 5'd0) ? OP_OPEN : (sub == 5'd16) ? OP_CLOSE : OP_MORE;
				o_word.payload.raw.data = burst_byte;
				last_sub = 5'd16;
				wait_units = (step == STEP_TEXT) ? 2'd2 : 2'd0;
			end
			STEP_ON: begin
				o_word.op = OP_CMD;
				o_word.payload.raw.data = DISPLAY_ON;
				wait_units = 2'd1;
			end
			STEP_LED: begin
				o_word.op = OP_LED;
				o_word.payload.indexed.idx = INIT_LED_IDX;
				o_word.payload.indexed.value = 8'h01;
				wait_units = 2'd1;
			end
			STEP_MASK: begin
				o_word.op = OP_LED;
				o_word.payload.indexed.idx = sub[3:0];
				o_word.payload.indexed.value = {7'b0, INIT_LED_MASK[sub[2:0]]};
				last_sub = 5'd7;
				wait_units = 2'd1;
			end
			STEP_LOOP: begin
				o_word.op = OP_LED;
				o_word.payload.indexed.idx = sub[3:0];
				o_word.payload.indexed.value = {7'b0, sub[2:0] == led_pos};
				last_sub = 5'd7;
				wait_units = btn_any ? 2'd2 : 2'd1;  // linger while a key is held
			end
			default: begin
				o_word.op = OP_READ;
			end
		endcase
	end

	assign wait_cycles = 8'(wait_units * WAIT_UNIT);
	assign drained = !o_req && !i_ack && i_eng_idle;  // nothing queued or on the bus

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			state <= SEQ_SEND;
			step <= STEP_MODE;
			sub <= 5'd0;
			led_pos <= 3'd0;
			btn_any <= 1'b0;
			wait_cnt <= 8'd0;
			o_req <= 1'b0;
		end else begin
			case (state)
				SEQ_SEND: begin
					if (!o_req && !i_ack) begin
						o_req <= 1'b1;
					end else if (o_req && i_ack) begin
						o_req <= 1'b0;
						if (sub != last_sub) begin
							sub <= sub + 5'd1;
						end else begin
							sub <= 5'd0;
							if (step == STEP_READ) begin
								state <= SEQ_READ;
							end else if (wait_units == 2'd0) begin
								step <= step + 3'd1;  // straight on keeps the FIFO busy
							end else begin
								wait_cnt <= 8'd0;
								state <= SEQ_WAIT;
							end
						end
					end
				end
				SEQ_WAIT: begin
					if (!drained) begin
						wait_cnt <= 8'd0;  // restart until the bus is quiet
					end else if (wait_cnt == wait_cycles) begin
						step <= step + 3'd1;
						state <= SEQ_SEND;
					end else begin
						wait_cnt <= wait_cnt + 8'd1;
					end
				end
				SEQ_READ: begin
					if (i_btn_valid) begin
						btn_any <= |i_btn_state;
						led_pos <= led_pos + 3'd1;  // wraps 7 -> 0
						step <= STEP_LOOP;
						state <= SEQ_SEND;
					end
				end
				default: begin
					state <= SEQ_SEND;
				end
			endcase
		end
	end

endmodule

//--- src/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo import ledkey_pkg::*; (
	input  logic      i_clk,
	input  logic      rst_n,
	input  logic      i_req,
	output logic      o_ack,
	input  cmd_word_t i_word,
	output logic      o_req,
	input  logic      i_ack,
	output cmd_word_t o_word
);

	cmd_word_t        mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign push = i_req && !o_ack && !full;  // new word from the sequencer
	assign pop  = o_req && i_ack;            // engine has taken the head

	assign o_word = mem[rd_ptr];  // stable while o_req is high

	always_ff @(posedge i_clk) begin
		if (push)
			mem[wr_ptr] <= i_word;
	end

	// write side handshake
	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			o_ack <= 1'b0;
			wr_ptr <= '0;
		end else if (push) begin
			o_ack <= 1'b1;
			wr_ptr <= wr_ptr + 1'b1;
		end else if (o_ack && !i_req) begin
			o_ack <= 1'b0;
		end
	end

	// read side handshake
	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			o_req <= 1'b0;
			rd_ptr <= '0;
		end else if (pop) begin
			o_req <= 1'b0;
			rd_ptr <= rd_ptr + 1'b1;
		end else if (!o_req && !i_ack && count != '0) begin
			o_req <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!rst_n)
			count <= '0;
		else if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end

endmodule

//--- src/tm1638_serial.sv
`timescale 1ns/10ps

module tm1638_serial import ledkey_pkg::*; (
	input  logic       i_clk,
	input  logic       rst_n,
	input  logic       i_req,
	output logic       o_ack,
	input  cmd_word_t  i_word,
	output logic       o_idle,
	output logic       o_stb,
	output logic       o_clk,
	output logic       o_dio,
	output logic       o_dio_oe,
	input  logic       i_dio,
	output logic       o_btn_valid,
	output logic [7:0] o_btn_state
);

	logic [2:0] state;
	cmd_word_t  word_r;
	logic [2:0] pos;       // byte slot inside the word
	logic [2:0] bit_cnt;
	logic [2:0] tmr;       // half bit and gap timer
	logic [7:0] sh;        // tx or rx shifter, LSB first
	logic [7:0] btn_acc;
	logic [7:0] btn_next;
	logic [1:0] rx_idx;
	logic [7:0] led_addr;
	logic [7:0] slot_byte;
	logic       slot_rx;
	logic       slot_end;  // strobe rises after this slot
	logic       slot_last;
	logic       half_done;

	assign led_addr = ADDR_BASE + {3'b000, word_r.payload.indexed.idx, 1'b0}
		+ {7'b0, word_r.op == OP_LED};  // LEDs sit on the odd addresses

	// byte slots of each op
	always_comb begin
		slot_byte = word_r.payload.raw.data;
		slot_rx = 1'b0;
		slot_end = 1'b0;
		slot_last = 1'b1;
		case (word_r.op)
			OP_OPEN, OP_MORE: begin
				slot_end = 1'b0;
			end
			OP_SEG, OP_LED: begin
				slot_last = (pos == 3'd2);
				slot_end = (pos != 3'd1);
				if (pos == 3'd0)
					slot_byte = MODE_FIXED;
				else if (pos == 3'd1)
					slot_byte = led_addr;
				else if (word_r.op == OP_LED)
					slot_byte = {7'b0, word_r.payload.indexed.value[0]};
				else
					slot_byte = word_r.payload.indexed.value;
			end
			OP_READ: begin
				slot_byte = MODE_READ;
				slot_rx = (pos != 3'd0);
				slot_last = (pos == 3'd4);
				slot_end = (pos == 3'd4);
			end
			default: begin
				slot_end = 1'b1;  // OP_CMD and OP_CLOSE
			end
		endcase
	end

	// read byte k holds keys k and k+4
	assign rx_idx = 2'(pos - 3'd1);
	always_comb begin
		btn_next = btn_acc;
		btn_next[{1'b0, rx_idx}] = sh[0];
		btn_next[{1'b1, rx_idx}] = sh[4];
	end

	assign half_done = (tmr == 3'(HALF_BIT - 1));
	assign o_idle = (state == SER_IDLE) && !o_ack;
	assign o_dio = sh[0];

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			state <= SER_IDLE;
			o_ack <= 1'b0;
			o_stb <= 1'b1;
			o_clk <= 1'b1;
			o_dio_oe <= 1'b0;
			o_btn_valid <= 1'b0;
			o_btn_state <= 8'h00;
			pos <= 3'd0;
			bit_cnt <= 3'd0;
			tmr <= 3'd0;
		end else begin
			o_btn_valid <= 1'b0;
			if (o_ack && !i_req)
				o_ack <= 1'b0;
			case (state)
				SER_IDLE: begin
					if (i_req && !o_ack) begin
						word_r <= i_word;
						o_ack <= 1'b1;
						pos <= 3'd0;
						state <= SER_LOAD;
					end
				end
				SER_LOAD: begin
					sh <= slot_rx ? 8'h00 : slot_byte;
					o_dio_oe <= !slot_rx;  // release the line for key data
					bit_cnt <= 3'd0;
					tmr <= 3'd0;
					if (o_stb) begin
						o_stb <= 1'b0;
						state <= SER_START;
					end else begin
						o_clk <= 1'b0;  // frame already open
						state <= SER_LOW;
					end
				end
				SER_START: begin
					tmr <= tmr + 3'd1;
					if (half_done) begin
						tmr <= 3'd0;
						o_clk <= 1'b0;
						state <= SER_LOW;
					end
				end
				SER_LOW: begin
					tmr <= tmr + 3'd1;
					if (half_done) begin
						tmr <= 3'd0;
						o_clk <= 1'b1;
						state <= SER_HIGH;
						if (slot_rx)
							sh <= {i_dio, sh[7:1]};  // sample at the rising edge
					end
				end
				SER_HIGH: begin
					tmr <= tmr + 3'd1;
					if (half_done) begin
						tmr <= 3'd0;
						if (bit_cnt != 3'd7) begin
							bit_cnt <= bit_cnt + 3'd1;
							o_clk <= 1'b0;
							state <= SER_LOW;
							if (!slot_rx)
								sh <= {1'b0, sh[7:1]};
						end else begin
							if (slot_rx) begin
								btn_acc <= btn_next;
								if (slot_last) begin
									o_btn_state <= btn_next;
									o_btn_valid <= 1'b1;
								end
							end
							if (slot_end) begin
								o_stb <= 1'b1;
								state <= SER_GAP;
							end else if (slot_last) begin
								state <= SER_IDLE;  // strobe stays low for the next word
							end else begin
								pos <= pos + 3'd1;
								state <= SER_LOAD;
							end
						end
					end
				end
				SER_GAP: begin
					tmr <= tmr + 3'd1;
					if (tmr == 3'(2 * HALF_BIT - 1)) begin
						tmr <= 3'd0;
						if (slot_last) begin
							state <= SER_IDLE;
						end else begin
							pos <= pos + 3'd1;
							state <= SER_LOAD;
						end
					end
				end
				default: begin
					state <= SER_IDLE;
				end
			endcase
		end
	end

endmodule

//--- src/ledkey_top.sv
`timescale 1ns/10ps

module ledkey_top import ledkey_pkg::*; (
	input  logic       i_clk,
	input  logic       rst_n,
	output logic       o_tm_stb,
	output logic       o_tm_clk,
	output logic       o_tm_dio,
	output logic       o_tm_dio_oe,
	input  logic       i_tm_dio,
	output logic [7:0] o_btn_state
);

	logic       seq_req;
	logic       seq_ack;
	cmd_word_t  seq_word;
	logic       fifo_req;
	logic       fifo_ack;
	cmd_word_t  fifo_word;
	logic       eng_idle;
	logic       btn_valid;
	logic [7:0] btn_state;

	assign o_btn_state = btn_state;

	ledkey_sequencer u_sequencer (
		.i_clk       (i_clk),
		.rst_n       (rst_n),
		.o_req       (seq_req),
		.i_ack       (seq_ack),
		.o_word      (seq_word),
		.i_eng_idle  (eng_idle),
		.i_btn_valid (btn_valid),
		.i_btn_state (btn_state)
	);

	cmd_fifo u_fifo (
		.i_clk  (i_clk),
		.rst_n  (rst_n),
		.i_req  (seq_req),
		.o_ack  (seq_ack),
		.i_word (seq_word),
		.o_req  (fifo_req),
		.i_ack  (fifo_ack),
		.o_word (fifo_word)
	);

	tm1638_serial u_serial (
		.i_clk       (i_clk),
		.rst_n       (rst_n),
		.i_req       (fifo_req),
		.o_ack       (fifo_ack),
		.i_word      (fifo_word),
		.o_idle      (eng_idle),
		.o_stb       (o_tm_stb),
		.o_clk       (o_tm_clk),
		.o_dio       (o_tm_dio),
		.o_dio_oe    (o_tm_dio_oe),  // board wrapper rebuilds the inout
		.i_dio       (i_tm_dio),
		.o_btn_valid (btn_valid),
		.o_btn_state (btn_state)
	);

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

	localparam int HALF_PERIOD = 5;   // 10 ns clock
	localparam int RESET_CYCLES = 8;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	initial begin
		o_rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;  // released on a rising edge
	end

endmodule

//--- sim/tb_ledkey.sv
`timescale 1ns/10ps

module tb_ledkey import ledkey_pkg::*; ();

	localparam int          NUM_PASSES  = 12;
	localparam logic [31:0] RAND_SEED   = 32'h4e33_e592;
	localparam logic [63:0] SHOW_TEXT   = "kill bit";
	localparam int          INIT_FRAMES = 22;       // mode, clear, on, text, 18 LED frames
	localparam int          PASS_FRAMES = 17;       // 16 LED frames and one read
	localparam int          MAX_BITS    = 17 * 8;   // longest frame is a 17 byte burst
	localparam int          WAIT_UNITS  = 5 + 2 * NUM_PASSES;
	localparam int          LIMIT_CYCLES = 4 * (8
		+ (INIT_FRAMES + NUM_PASSES * PASS_FRAMES) * MAX_BITS * 2 * HALF_BIT
		+ WAIT_UNITS * WAIT_UNIT);

	logic       i_clk;
	logic       rst_n;
	logic       tm_stb;
	logic       tm_clk;
	logic       tm_dio;
	logic       tm_dio_oe;
	logic       tm_dio_in;
	logic [7:0] btn_state;

	logic [7:0] btn_pat [NUM_PASSES];  // key pattern per idle pass
	logic [7:0] rx_bytes[$];           // bytes seen on the bus
	int         rx_lens[$];
	logic [7:0] exp_bytes[$];
	int         exp_lens[$];
	string      exp_names[$];

	tb_clkgen u_clkgen (
		.o_clk   (i_clk),
		.o_rst_n (rst_n)
	);

	ledkey_top dut0 (
		.i_clk       (i_clk),
		.rst_n       (rst_n),
		.o_tm_stb    (tm_stb),
		.o_tm_clk    (tm_clk),
		.o_tm_dio    (tm_dio),
		.o_tm_dio_oe (tm_dio_oe),
		.i_tm_dio    (tm_dio_in),
		.o_btn_state (btn_state)
	);

	// key k on bit 0 of byte k, key k+4 on bit 4
	function automatic logic [7:0] key_byte(input logic [7:0] pattern, input logic [1:0] k);
		logic [7:0] b;
		logic [2:0] lo;
		b = 8'h00;
		lo = {1'b0, k};
		b[0] = pattern[lo];
		b[4] = pattern[lo + 3'd4];
		return b;
	endfunction

	function automatic void open_frame(input string name);
		exp_names.push_back(name);
		exp_lens.push_back(0);
	endfunction

	function automatic void add_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
		exp_lens[exp_lens.size() - 1] += 1;
	endfunction

	// fixed mode frame, then odd address and LED bit
	function automatic void led_pair(input string name, input int idx, input logic on);
		open_frame($sformatf("%s led %0d mode", name, idx));
		add_byte(MODE_FIXED);
		open_frame($sformatf("%s led %0d write", name, idx));
		add_byte(8'(ADDR_BASE + 2 * idx + 1));
		add_byte({7'b0, on});
	endfunction

	// pass below zero is the init script
	function automatic void expected_frames(input int pass);
		int i;
		int n;
		if (pass < 0) begin
			open_frame("init mode");
			add_byte(MODE_AUTO);
			open_frame("init clear");
			add_byte(ADDR_BASE);
			for (i = 0; i < 16; i++)
				add_byte(8'h00);
			open_frame("init display on");
			add_byte(8'h88);
			open_frame("init text");
			add_byte(ADDR_BASE);
			for (i = 0; i < 8; i++) begin
				add_byte(glyph(SHOW_TEXT[6'(8 * (7 - i)) +: 8]));  // first char in the top byte
				add_byte(8'h00);
			end
			led_pair("init single", int'(INIT_LED_IDX), 1'b1);
			for (i = 0; i < 8; i++)
				led_pair("init mask", i, INIT_LED_MASK[3'(i)]);
		end else begin
			n = pass % 8;
			for (i = 0; i < 8; i++)
				led_pair($sformatf("pass %0d", pass), i, i == n);
			open_frame($sformatf("pass %0d read", pass));
			add_byte(MODE_READ);
			for (i = 0; i < 4; i++)
				add_byte(key_byte(btn_pat[pass], 2'(i)));
		end
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			fail_run($sformatf("[FAIL] %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic check_btn(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			fail_run($sformatf("[FAIL] %s: expected %08b, actual %08b", name, exp, act));
	endtask

	task automatic check_op(input string name, input int exp, input int act);
		if (act != exp)
			fail_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_pin(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic take_frame(output int len);
		while (rx_lens.size() == 0)
			@(posedge i_clk);
		len = rx_lens.pop_front();
	endtask

	task automatic compare_frames();
		string      name;
		int         exp_len;
		int         act_len;
		int         i;
		logic [7:0] e;
		logic [7:0] a;
		while (exp_lens.size() > 0) begin
			name = exp_names.pop_front();
			exp_len = exp_lens.pop_front();
			take_frame(act_len);
			check_op({name, " length"}, exp_len, act_len);
			for (i = 0; i < exp_len; i++) begin
				e = exp_bytes.pop_front();
				a = rx_bytes.pop_front();
				check_byte($sformatf("%s byte %0d", name, i), e, a);
			end
		end
	endtask

	// TM1638 side collecting bytes LSB first at the rising serial clock
	initial begin : bus_model
		logic       prev_stb;
		logic       prev_sclk;
		logic [7:0] cur_byte;
		logic [2:0] bit_idx;
		logic [7:0] pat;
		logic [7:0] resp;
		logic       dio_bit;
		logic [7:0] frame_q[$];
		int         read_cnt;
		tm_dio_in <= 1'b1;
		prev_stb = 1'b1;
		prev_sclk = 1'b1;
		cur_byte = 8'h00;
		bit_idx = 3'd0;
		pat = 8'h00;
		read_cnt = 0;
		while (rst_n !== 1'b1)
			@(posedge i_clk);
		forever begin
			@(posedge i_clk);
			if (prev_stb && !tm_stb) begin
				frame_q.delete();
				cur_byte = 8'h00;
				bit_idx = 3'd0;
			end
			if (!tm_stb && tm_clk && !prev_sclk) begin
				dio_bit = tm_dio_oe ? tm_dio : tm_dio_in;
				cur_byte[bit_idx] = dio_bit;
				if (bit_idx == 3'd7) begin
					frame_q.push_back(cur_byte);
					cur_byte = 8'h00;
					if (frame_q.size() == 1 && frame_q[0] == MODE_READ)
						pat = btn_pat[read_cnt % NUM_PASSES];  // keys held for this read
				end
				bit_idx = bit_idx + 3'd1;
			end
			if (!prev_stb && tm_stb) begin
				foreach (frame_q[i])
					rx_bytes.push_back(frame_q[i]);
				rx_lens.push_back(frame_q.size());
				if (frame_q.size() > 0 && frame_q[0] == MODE_READ)
					read_cnt++;
			end
			if (!tm_stb && frame_q.size() >= 1 && frame_q.size() <= 4
				&& frame_q[0] == MODE_READ) begin
				resp = key_byte(pat, 2'(frame_q.size() - 1));
				tm_dio_in <= resp[bit_idx];
			end else begin
				tm_dio_in <= 1'b1;  // pull-up while released
			end
			prev_stb = tm_stb;
			prev_sclk = tm_clk;
		end
	end

	initial begin : compare
		int pass;
		void'($urandom(RAND_SEED));
		for (pass = 0; pass < NUM_PASSES; pass++)
			btn_pat[pass] = 8'($urandom);
		while (rst_n !== 1'b1)
			@(posedge i_clk);
		check_pin("reset stb", 1'b1, tm_stb);
		check_pin("reset clk", 1'b1, tm_clk);
		check_pin("reset dio_oe", 1'b0, tm_dio_oe);
		check_btn("reset buttons", 8'h00, btn_state);
		expected_frames(-1);
		compare_frames();
		for (pass = 0; pass < NUM_PASSES; pass++) begin
			expected_frames(pass);
			compare_frames();
			check_btn($sformatf("pass %0d buttons", pass), btn_pat[pass], btn_state);
		end
		$display("Finished with no errors");
		$finish;
	end

	initial begin : watchdog
		repeat (LIMIT_CYCLES) @(posedge i_clk);
		fail_run($sformatf("the run hung: not done after %0d clock cycles", LIMIT_CYCLES));
	end

endmodule

//--- list.f
src/ledkey_pkg.sv
src/ledkey_sequencer.sv
src/cmd_fifo.sv
src/tm1638_serial.sv
src/ledkey_top.sv
sim/tb_clkgen.sv
sim/tb_ledkey.sv

//--- run.sh
#!/bin/sh
# build the ledkey testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/10ps --top-module tb_ledkey -f list.f

out=$(./obj_dir/Vtb_ledkey) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "simulation did not pass"
exit 1
